/* umi_pkg.sv */
package umi_pkg;

   typedef logic [31:0] umi_cmd_t;      // One command word
   typedef logic [4:0]  umi_opcode_t;
   typedef logic [2:0]  umi_size_t;     // Log2 of bytes per word
   typedef logic [7:0]  umi_len_t;
   typedef logic [7:0]  umi_atype_t;
   typedef logic [4:0]  umi_hostid_t;
   typedef logic [23:0] umi_uext_t;     // Replaces all fields above size

   // Requests, bit 0 set
   localparam umi_opcode_t UMI_REQ_READ   = 5'd1;
   localparam umi_opcode_t UMI_REQ_WRITE  = 5'd3;
   localparam umi_opcode_t UMI_REQ_ATOMIC = 5'd9;
   localparam umi_opcode_t UMI_REQ_LINK   = 5'd15;

   // Responses, bit 0 clear
   localparam umi_opcode_t UMI_RESP_READ  = 5'd2;
   localparam umi_opcode_t UMI_RESP_WRITE = 5'd4;
   localparam umi_opcode_t UMI_RESP_ERROR = 5'd12;
   localparam umi_opcode_t UMI_RESP_LINK  = 5'd14;

   localparam umi_atype_t UMI_ATOMIC_ADD  = 8'h00;
   localparam umi_atype_t UMI_ATOMIC_SWAP = 8'h08;

   // Field lsb positions in the word
   localparam int UMI_OPCODE_LSB = 0;
   localparam int UMI_SIZE_LSB   = 5;
   localparam int UMI_LEN_LSB    = 8;   // Atype for atomics
   localparam int UMI_QOS_LSB    = 16;
   localparam int UMI_PROT_LSB   = 20;
   localparam int UMI_EOM_BIT    = 22;
   localparam int UMI_EOF_BIT    = 23;
   localparam int UMI_EX_BIT     = 24;
   localparam int UMI_USER_LSB   = 25;  // Err for responses
   localparam int UMI_HOSTID_LSB = 27;
   localparam int UMI_UEXT_LSB   = 8;   // Extended user starts above size

endpackage

/* umi_mem_pkg.sv */
package umi_mem_pkg;

   localparam int MEM_AW    = 8;
   localparam int MEM_DEPTH = 256;      // Words in the target memory

   typedef logic [MEM_AW-1:0] mem_addr_t;
   typedef logic [31:0]       mem_data_t;
   typedef logic              host_sel_t; // Arbiter grant index

endpackage

/* umi_decode.sv */
`timescale 1ns/1ns

module umi_decode (
   input  umi_pkg::umi_cmd_t command,
   output logic              cmd_invalid,
   output logic              cmd_request,
   output logic              cmd_response,
   output logic              cmd_read,
   output logic              cmd_write,
   output logic              cmd_atomic,
   output logic              cmd_error,
   output logic              cmd_link,
   output logic              cmd_link_resp
);

   import umi_pkg::*;

   umi_opcode_t opcode;
   logic        read_resp;                // Not exported, only for validity
   logic        write_resp;

   assign opcode = command[UMI_OPCODE_LSB +: $bits(umi_opcode_t)];

   assign cmd_read      = opcode == UMI_REQ_READ;
   assign cmd_write     = opcode == UMI_REQ_WRITE;
   assign cmd_atomic    = opcode == UMI_REQ_ATOMIC;
   assign cmd_link      = opcode == UMI_REQ_LINK;
   assign read_resp     = opcode == UMI_RESP_READ;
   assign write_resp    = opcode == UMI_RESP_WRITE;
   assign cmd_error     = opcode == UMI_RESP_ERROR;
   assign cmd_link_resp = opcode == UMI_RESP_LINK;

   assign cmd_request  = opcode[0];               // Requests are odd
   assign cmd_response = ~opcode[0] & (|opcode);  // Zero is no command

   // Nothing known matched
   assign cmd_invalid = ~(cmd_read | cmd_write | cmd_atomic | cmd_link |
                          read_resp | write_resp | cmd_error | cmd_link_resp);

endmodule

/* umi_pack.sv */
`timescale 1ns/1ns

module umi_pack (
   input  umi_pkg::umi_opcode_t cmd_opcode,
   input  umi_pkg::umi_size_t   cmd_size,
   input  umi_pkg::umi_len_t    cmd_len,
   input  umi_pkg::umi_atype_t  cmd_atype,
   input  logic [1:0]           cmd_prot,
   input  logic [3:0]           cmd_qos,
   input  logic                 cmd_eom,
   input  logic                 cmd_eof,
   input  logic [1:0]           cmd_user,
   input  logic [1:0]           cmd_err,
   input  logic                 cmd_ex,
   input  umi_pkg::umi_hostid_t cmd_hostid,
   input  umi_pkg::umi_uext_t   cmd_user_extended,
   output umi_pkg::umi_cmd_t    packet_cmd
);

   import umi_pkg::*;

   logic cmd_response;
   logic cmd_atomic;
   logic cmd_error;
   logic cmd_link;
   logic cmd_link_resp;
   logic ext_sel;                          // Extended user replaces upper fields

   umi_decode i_umi_decode (
      .command       (umi_cmd_t'(cmd_opcode)), // Opcode alone picks the format
      .cmd_invalid   (),
      .cmd_request   (),
      .cmd_response  (cmd_response),
      .cmd_read      (),
      .cmd_write     (),
      .cmd_atomic    (cmd_atomic),
      .cmd_error     (cmd_error),
      .cmd_link      (cmd_link),
      .cmd_link_resp (cmd_link_resp)
   );

   assign ext_sel = cmd_link | cmd_link_resp | cmd_error;

   always_comb begin
      packet_cmd = '0;
      packet_cmd[UMI_OPCODE_LSB +: 5] = cmd_opcode;
      if (cmd_link) begin
         packet_cmd[UMI_SIZE_LSB +: 3] = 3'd1;  // Link is always size 1
      end else if (!(cmd_link_resp | cmd_error)) begin
         packet_cmd[UMI_SIZE_LSB +: 3] = cmd_size;
      end
      if (ext_sel) begin
         packet_cmd[UMI_UEXT_LSB +: 24] = cmd_user_extended;
      end else begin
         packet_cmd[UMI_LEN_LSB +: 8]     = cmd_atomic ? cmd_atype : cmd_len;
         packet_cmd[UMI_QOS_LSB +: 4]     = cmd_qos;
         packet_cmd[UMI_PROT_LSB +: 2]    = cmd_prot;
         packet_cmd[UMI_EOM_BIT]          = cmd_eom;
         packet_cmd[UMI_EOF_BIT]          = cmd_eof;
         packet_cmd[UMI_EX_BIT]           = cmd_ex;
         packet_cmd[UMI_USER_LSB +: 2]    = cmd_response ? cmd_err : cmd_user;
         packet_cmd[UMI_HOSTID_LSB +: 5]  = cmd_hostid;
      end
   end

endmodule

/* umi_host_port.sv */
`timescale 1ns/1ns

module umi_host_port (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   req_valid,
   output logic                   req_ready,
   input  umi_pkg::umi_opcode_t   req_opcode,
   input  umi_pkg::umi_size_t     req_size,
   input  umi_pkg::umi_len_t      req_len,
   input  umi_pkg::umi_atype_t    req_atype,
   input  logic [3:0]             req_qos,
   input  logic [1:0]             req_prot,
   input  logic                   req_eom,
   input  logic                   req_eof,
   input  logic                   req_ex,
   input  logic [1:0]             req_user,
   input  umi_pkg::umi_hostid_t   req_hostid,
   input  umi_pkg::umi_uext_t     req_uext,
   input  umi_mem_pkg::mem_addr_t req_addr,
   input  umi_mem_pkg::mem_data_t req_wdata,
   output logic                   rsp_valid,
   output umi_pkg::umi_cmd_t      rsp_cmd,
   output umi_mem_pkg::mem_data_t rsp_data,
   output logic                   cyc,
   output logic                   stb,
   output logic                   we,
   output umi_mem_pkg::mem_addr_t adr,
   output umi_mem_pkg::mem_data_t dat_w,
   output umi_pkg::umi_cmd_t      tag_cmd,
   input  logic                   ack,
   input  umi_mem_pkg::mem_data_t dat_r,
   input  umi_pkg::umi_cmd_t      tag_rsp
);

   import umi_pkg::*;

   typedef enum logic [1:0] {ST_IDLE, ST_BUS, ST_DONE} state_t;

   state_t   state;
   umi_cmd_t req_cmd;                      // Packed request word
   logic     accept;

   umi_pack i_umi_pack (
      .cmd_opcode (req_opcode), .cmd_size (req_size), .cmd_len (req_len),
      .cmd_atype  (req_atype),  .cmd_prot (req_prot), .cmd_qos (req_qos),
      .cmd_eom    (req_eom),    .cmd_eof  (req_eof),  .cmd_user (req_user),
      .cmd_err    (2'b00),      .cmd_ex   (req_ex),   .cmd_hostid (req_hostid),
      .cmd_user_extended (req_uext),
      .packet_cmd (req_cmd)
   );

   assign req_ready = state == ST_IDLE;    // Back-pressure while busy
   assign accept    = req_valid & req_ready;
   assign stb       = cyc;
   assign rsp_valid = state == ST_DONE;    // One cycle, follows ack

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_IDLE;
         cyc   <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: if (accept) state <= ST_BUS;
            ST_BUS: begin
               if (!cyc) begin
                  cyc <= 1'b1;             // Launch cycle after acceptance
               end else if (ack) begin
                  cyc   <= 1'b0;
                  state <= ST_DONE;
               end
            end
            default: state <= ST_IDLE;     // Done returns to idle
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         tag_cmd <= req_cmd;
         adr     <= req_addr;
         dat_w   <= req_wdata;
         we      <= req_opcode == UMI_REQ_WRITE;
      end
      if (cyc && ack) begin
         rsp_cmd  <= tag_rsp;              // Capture response
         rsp_data <= dat_r;
      end
   end

endmodule

/* umi_arbiter.sv */
`timescale 1ns/1ns

module umi_arbiter (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   m0_cyc,
   input  logic                   m0_stb,
   input  logic                   m0_we,
   input  umi_mem_pkg::mem_addr_t m0_adr,
   input  umi_mem_pkg::mem_data_t m0_dat_w,
   input  umi_pkg::umi_cmd_t      m0_tag_cmd,
   output logic                   m0_ack,
   output umi_mem_pkg::mem_data_t m0_dat_r,
   output umi_pkg::umi_cmd_t      m0_tag_rsp,
   input  logic                   m1_cyc,
   input  logic                   m1_stb,
   input  logic                   m1_we,
   input  umi_mem_pkg::mem_addr_t m1_adr,
   input  umi_mem_pkg::mem_data_t m1_dat_w,
   input  umi_pkg::umi_cmd_t      m1_tag_cmd,
   output logic                   m1_ack,
   output umi_mem_pkg::mem_data_t m1_dat_r,
   output umi_pkg::umi_cmd_t      m1_tag_rsp,
   output logic                   s_cyc,
   output logic                   s_stb,
   output logic                   s_we,
   output umi_mem_pkg::mem_addr_t s_adr,
   output umi_mem_pkg::mem_data_t s_dat_w,
   output umi_pkg::umi_cmd_t      s_tag_cmd,
   input  logic                   s_ack,
   input  umi_mem_pkg::mem_data_t s_dat_r,
   input  umi_pkg::umi_cmd_t      s_tag_rsp
);

   import umi_mem_pkg::*;

   host_sel_t gnt;                         // Current, else last granted
   host_sel_t next_sel;
   logic      gnt_valid;
   logic      gnt_cyc;                     // Granted master still in cycle
   logic      sel0;
   logic      sel1;

   assign gnt_cyc  = gnt ? m1_cyc : m0_cyc;
   assign next_sel = (m0_cyc & m1_cyc) ? ~gnt : m1_cyc; // Last winner loses tie
   assign sel0     = gnt_valid & ~gnt;
   assign sel1     = gnt_valid & gnt;

   always_ff @(posedge clk) begin
      if (rst) begin
         gnt_valid <= 1'b0;
         gnt       <= 1'b0;
      end else if (!gnt_valid || !gnt_cyc) begin  // Bus idle, arbitrate
         gnt_valid <= m0_cyc | m1_cyc;
         if (m0_cyc || m1_cyc) gnt <= next_sel;
      end
   end

   assign s_cyc     = gnt_valid & gnt_cyc;
   assign s_stb     = gnt_valid & (gnt ? m1_stb : m0_stb);
   assign s_we      = gnt ? m1_we      : m0_we;
   assign s_adr     = gnt ? m1_adr     : m0_adr;
   assign s_dat_w   = gnt ? m1_dat_w   : m0_dat_w;
   assign s_tag_cmd = gnt ? m1_tag_cmd : m0_tag_cmd;

   // Return path only to the granted master
   assign m0_ack     = s_ack & sel0;
   assign m1_ack     = s_ack & sel1;
   assign m0_dat_r   = sel0 ? s_dat_r   : '0;
   assign m1_dat_r   = sel1 ? s_dat_r   : '0;
   assign m0_tag_rsp = sel0 ? s_tag_rsp : '0;
   assign m1_tag_rsp = sel1 ? s_tag_rsp : '0;

endmodule

/* umi_mem_target.sv */
`timescale 1ns/1ns

module umi_mem_target (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   cyc,
   input  logic                   stb,
   input  logic                   we,
   input  umi_mem_pkg::mem_addr_t adr,
   input  umi_mem_pkg::mem_data_t dat_w,
   input  umi_pkg::umi_cmd_t      tag_cmd,
   output logic                   ack,
   output umi_mem_pkg::mem_data_t dat_r,
   output umi_pkg::umi_cmd_t      tag_rsp
);

   import umi_pkg::*;
   import umi_mem_pkg::*;

   mem_data_t   mem [MEM_DEPTH];
   mem_data_t   old_data;                  // Word before this access
   umi_atype_t  atype;
   umi_opcode_t rsp_opcode;
   umi_cmd_t    rsp_cmd;
   logic        access;
   logic        do_add;
   logic        do_swap;
   logic        bad_req;                   // Answered with an error
   logic        cmd_read;
   logic        cmd_write;
   logic        cmd_atomic;
   logic        cmd_link;

   umi_decode i_umi_decode (
      .command       (tag_cmd),
      .cmd_invalid   (),
      .cmd_request   (),
      .cmd_response  (),
      .cmd_read      (cmd_read),
      .cmd_write     (cmd_write),
      .cmd_atomic    (cmd_atomic),
      .cmd_error     (),
      .cmd_link      (cmd_link),
      .cmd_link_resp ()
   );

   assign access   = cyc & stb & ~ack;     // Second beat under ack ignored
   assign old_data = mem[adr];
   assign atype    = tag_cmd[UMI_LEN_LSB +: 8];
   assign do_add   = cmd_atomic & (atype == UMI_ATOMIC_ADD);
   assign do_swap  = cmd_atomic & (atype == UMI_ATOMIC_SWAP);
   assign bad_req  = ~(cmd_read | cmd_write | do_add | do_swap | cmd_link);

   always_comb begin
      if (bad_req)        rsp_opcode = UMI_RESP_ERROR;
      else if (cmd_link)  rsp_opcode = UMI_RESP_LINK;
      else if (cmd_write) rsp_opcode = UMI_RESP_WRITE;
      else                rsp_opcode = UMI_RESP_READ;  // Read and atomics
   end

   umi_pack i_umi_pack (
      .cmd_opcode (rsp_opcode),
      .cmd_size   (tag_cmd[UMI_SIZE_LSB +: 3]),
      .cmd_len    (tag_cmd[UMI_LEN_LSB +: 8]),
      .cmd_atype  (atype),
      .cmd_prot   (tag_cmd[UMI_PROT_LSB +: 2]),
      .cmd_qos    (tag_cmd[UMI_QOS_LSB +: 4]),
      .cmd_eom    (tag_cmd[UMI_EOM_BIT]),
      .cmd_eof    (tag_cmd[UMI_EOF_BIT]),
      .cmd_user   (tag_cmd[UMI_USER_LSB +: 2]),
      .cmd_err    (2'b00),
      .cmd_ex     (tag_cmd[UMI_EX_BIT]),
      .cmd_hostid (tag_cmd[UMI_HOSTID_LSB +: 5]),
      .cmd_user_extended (tag_cmd[UMI_UEXT_LSB +: 24]), // Link and error echo
      .packet_cmd (rsp_cmd)
   );

   always_ff @(posedge clk) begin
      if (access) begin
         if (we || do_swap) mem[adr] <= dat_w;
         else if (do_add)   mem[adr] <= old_data + dat_w;
         dat_r   <= old_data;              // Old value for atomics
         tag_rsp <= rsp_cmd;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) ack <= 1'b0;
      else     ack <= access;              // Single-cycle ack
   end

endmodule

/* umi_mem_top.sv */
`timescale 1ns/1ns

module umi_mem_top (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   h0_req_valid,
   output logic                   h0_req_ready,
   input  umi_pkg::umi_opcode_t   h0_req_opcode,
   input  umi_pkg::umi_size_t     h0_req_size,
   input  umi_pkg::umi_len_t      h0_req_len,
   input  umi_pkg::umi_atype_t    h0_req_atype,
   input  logic [3:0]             h0_req_qos,
   input  logic [1:0]             h0_req_prot,
   input  logic                   h0_req_eom,
   input  logic                   h0_req_eof,
   input  logic                   h0_req_ex,
   input  logic [1:0]             h0_req_user,
   input  umi_pkg::umi_hostid_t   h0_req_hostid,
   input  umi_pkg::umi_uext_t     h0_req_uext,
   input  umi_mem_pkg::mem_addr_t h0_req_addr,
   input  umi_mem_pkg::mem_data_t h0_req_wdata,
   output logic                   h0_rsp_valid,
   output umi_pkg::umi_cmd_t      h0_rsp_cmd,
   output umi_mem_pkg::mem_data_t h0_rsp_data,
   input  logic                   h1_req_valid,
   output logic                   h1_req_ready,
   input  umi_pkg::umi_opcode_t   h1_req_opcode,
   input  umi_pkg::umi_size_t     h1_req_size,
   input  umi_pkg::umi_len_t      h1_req_len,
   input  umi_pkg::umi_atype_t    h1_req_atype,
   input  logic [3:0]             h1_req_qos,
   input  logic [1:0]             h1_req_prot,
   input  logic                   h1_req_eom,
   input  logic                   h1_req_eof,
   input  logic                   h1_req_ex,
   input  logic [1:0]             h1_req_user,
   input  umi_pkg::umi_hostid_t   h1_req_hostid,
   input  umi_pkg::umi_uext_t     h1_req_uext,
   input  umi_mem_pkg::mem_addr_t h1_req_addr,
   input  umi_mem_pkg::mem_data_t h1_req_wdata,
   output logic                   h1_rsp_valid,
   output umi_pkg::umi_cmd_t      h1_rsp_cmd,
   output umi_mem_pkg::mem_data_t h1_rsp_data
);

   import umi_pkg::*;
   import umi_mem_pkg::*;

   // Master side buses, one per host port
   logic      m0_cyc, m0_stb, m0_we, m0_ack;
   logic      m1_cyc, m1_stb, m1_we, m1_ack;
   mem_addr_t m0_adr, m1_adr;
   mem_data_t m0_dat_w, m0_dat_r, m1_dat_w, m1_dat_r;
   umi_cmd_t  m0_tag_cmd, m0_tag_rsp, m1_tag_cmd, m1_tag_rsp;
   // Shared slave bus
   logic      s_cyc, s_stb, s_we, s_ack;
   mem_addr_t s_adr;
   mem_data_t s_dat_w, s_dat_r;
   umi_cmd_t  s_tag_cmd, s_tag_rsp;

   umi_host_port i_host0 (
      .clk (clk), .rst (rst),
      .req_valid (h0_req_valid), .req_ready (h0_req_ready), .req_opcode (h0_req_opcode),
      .req_size (h0_req_size), .req_len (h0_req_len), .req_atype (h0_req_atype),
      .req_qos (h0_req_qos), .req_prot (h0_req_prot), .req_eom (h0_req_eom),
      .req_eof (h0_req_eof), .req_ex (h0_req_ex), .req_user (h0_req_user),
      .req_hostid (h0_req_hostid), .req_uext (h0_req_uext), .req_addr (h0_req_addr),
      .req_wdata (h0_req_wdata),
      .rsp_valid (h0_rsp_valid), .rsp_cmd (h0_rsp_cmd), .rsp_data (h0_rsp_data),
      .cyc (m0_cyc), .stb (m0_stb), .we (m0_we), .adr (m0_adr), .dat_w (m0_dat_w),
      .tag_cmd (m0_tag_cmd), .ack (m0_ack), .dat_r (m0_dat_r), .tag_rsp (m0_tag_rsp)
   );

   umi_host_port i_host1 (
      .clk (clk), .rst (rst),
      .req_valid (h1_req_valid), .req_ready (h1_req_ready), .req_opcode (h1_req_opcode),
      .req_size (h1_req_size), .req_len (h1_req_len), .req_atype (h1_req_atype),
      .req_qos (h1_req_qos), .req_prot (h1_req_prot), .req_eom (h1_req_eom),
      .req_eof (h1_req_eof), .req_ex (h1_req_ex), .req_user (h1_req_user),
      .req_hostid (h1_req_hostid), .req_uext (h1_req_uext), .req_addr (h1_req_addr),
      .req_wdata (h1_req_wdata),
      .rsp_valid (h1_rsp_valid), .rsp_cmd (h1_rsp_cmd), .rsp_data (h1_rsp_data),
      .cyc (m1_cyc), .stb (m1_stb), .we (m1_we), .adr (m1_adr), .dat_w (m1_dat_w),
      .tag_cmd (m1_tag_cmd), .ack (m1_ack), .dat_r (m1_dat_r), .tag_rsp (m1_tag_rsp)
   );

   umi_arbiter i_umi_arbiter (
      .clk (clk), .rst (rst),
      .m0_cyc (m0_cyc), .m0_stb (m0_stb), .m0_we (m0_we), .m0_adr (m0_adr),
      .m0_dat_w (m0_dat_w), .m0_tag_cmd (m0_tag_cmd), .m0_ack (m0_ack),
      .m0_dat_r (m0_dat_r), .m0_tag_rsp (m0_tag_rsp),
      .m1_cyc (m1_cyc), .m1_stb (m1_stb), .m1_we (m1_we), .m1_adr (m1_adr),
      .m1_dat_w (m1_dat_w), .m1_tag_cmd (m1_tag_cmd), .m1_ack (m1_ack),
      .m1_dat_r (m1_dat_r), .m1_tag_rsp (m1_tag_rsp),
      .s_cyc (s_cyc), .s_stb (s_stb), .s_we (s_we), .s_adr (s_adr),
      .s_dat_w (s_dat_w), .s_tag_cmd (s_tag_cmd), .s_ack (s_ack),
      .s_dat_r (s_dat_r), .s_tag_rsp (s_tag_rsp)
   );

   umi_mem_target i_umi_mem_target (
      .clk (clk), .rst (rst),
      .cyc (s_cyc), .stb (s_stb), .we (s_we), .adr (s_adr), .dat_w (s_dat_w),
      .tag_cmd (s_tag_cmd), .ack (s_ack), .dat_r (s_dat_r), .tag_rsp (s_tag_rsp)
   );

endmodule

/* tb_umi_mem.sv */
`timescale 1ns/1ns

module tb_umi_mem;

   import umi_pkg::*;
   import umi_mem_pkg::*;

   localparam int          CYCLE_LIMIT  = 3000;   // Roughly 5x the full run
   localparam host_sel_t   HOST0        = 1'b0;
   localparam host_sel_t   HOST1        = 1'b1;
   localparam umi_opcode_t UNDEF_OPCODE = 5'd5;   // Not a known opcode

   logic        clk;
   logic        rst;
   logic        req_valid  [2];                   // Index is the host
   logic        req_ready  [2];
   umi_opcode_t req_opcode [2];
   umi_size_t   req_size   [2];
   umi_len_t    req_len    [2];
   umi_atype_t  req_atype  [2];
   logic [3:0]  req_qos    [2];
   logic [1:0]  req_prot   [2];
   logic        req_eom    [2];
   logic        req_eof    [2];
   logic        req_ex     [2];
   logic [1:0]  req_user   [2];
   umi_hostid_t req_hostid [2];
   umi_uext_t   req_uext   [2];
   mem_addr_t   req_addr   [2];
   mem_data_t   req_wdata  [2];
   logic        rsp_valid  [2];
   umi_cmd_t    rsp_cmd    [2];
   mem_data_t   rsp_data   [2];

   mem_data_t   model [MEM_DEPTH];                // Reference memory
   host_sel_t   done_order [$];                   // Completion order under contention
   integer      seed = 32'h311f;
   int          checks = 0;
   int          errors = 0;
   int          cycles = 0;

   umi_mem_top i_umi_mem_top (
      .clk (clk), .rst (rst),
      .h0_req_valid (req_valid[0]), .h0_req_ready (req_ready[0]),
      .h0_req_opcode (req_opcode[0]), .h0_req_size (req_size[0]), .h0_req_len (req_len[0]),
      .h0_req_atype (req_atype[0]), .h0_req_qos (req_qos[0]), .h0_req_prot (req_prot[0]),
      .h0_req_eom (req_eom[0]), .h0_req_eof (req_eof[0]), .h0_req_ex (req_ex[0]),
      .h0_req_user (req_user[0]), .h0_req_hostid (req_hostid[0]), .h0_req_uext (req_uext[0]),
      .h0_req_addr (req_addr[0]), .h0_req_wdata (req_wdata[0]),
      .h0_rsp_valid (rsp_valid[0]), .h0_rsp_cmd (rsp_cmd[0]), .h0_rsp_data (rsp_data[0]),
      .h1_req_valid (req_valid[1]), .h1_req_ready (req_ready[1]),
      .h1_req_opcode (req_opcode[1]), .h1_req_size (req_size[1]), .h1_req_len (req_len[1]),
      .h1_req_atype (req_atype[1]), .h1_req_qos (req_qos[1]), .h1_req_prot (req_prot[1]),
      .h1_req_eom (req_eom[1]), .h1_req_eof (req_eof[1]), .h1_req_ex (req_ex[1]),
      .h1_req_user (req_user[1]), .h1_req_hostid (req_hostid[1]), .h1_req_uext (req_uext[1]),
      .h1_req_addr (req_addr[1]), .h1_req_wdata (req_wdata[1]),
      .h1_rsp_valid (rsp_valid[1]), .h1_rsp_cmd (rsp_cmd[1]), .h1_rsp_data (rsp_data[1])
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;                      // 4 ns period
   end

   initial begin
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: no end of test after %0d cycles", CYCLE_LIMIT);
      $display("** FAIL **");
      $finish;
   end

   task automatic check_cmd(input string what, input umi_cmd_t got, input umi_cmd_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_data(input string what, input mem_data_t got, input mem_data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_host(input string what, input host_sel_t got, input host_sel_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t ns: %s got host %0d expected host %0d", $time, what, got, exp);
      end
   endtask

   // Response word built from the request word by the UMI layout
   function automatic umi_cmd_t expect_response(input umi_cmd_t req, input umi_opcode_t op);
      if (op == UMI_RESP_LINK || op == UMI_RESP_ERROR) begin
         return {req[31:8], 3'd0, op};            // Upper bits echoed with size zero
      end
      return {req[31:27], 2'b00, req[24:5], op};  // Err of zero in the user slot
   endfunction

   task automatic init_inputs();
      rst = 1'b1;
      for (int h = 0; h < 2; h++) begin
         req_valid[h]  = 1'b0;
         req_opcode[h] = '0;
         req_size[h]   = '0;
         req_len[h]    = '0;
         req_atype[h]  = '0;
         req_qos[h]    = '0;
         req_prot[h]   = '0;
         req_eom[h]    = 1'b0;
         req_eof[h]    = 1'b0;
         req_ex[h]     = 1'b0;
         req_user[h]   = '0;
         req_hostid[h] = '0;
         req_uext[h]   = '0;
         req_addr[h]   = '0;
         req_wdata[h]  = '0;
      end
   endtask

   // Drive one request with random side fields and wait for its response
   task automatic run_request(input host_sel_t h, input umi_opcode_t op, input umi_atype_t at,
                              input mem_addr_t addr, input mem_data_t wdata,
                              output umi_cmd_t req_word, output umi_cmd_t rsp_word,
                              output mem_data_t rsp_dat);
      logic [31:0] rnd;
      umi_len_t    len_slot;
      @(negedge clk);
      rnd = $random(seed);
      req_opcode[h] = op;
      req_atype[h]  = at;
      req_size[h]   = rnd[2:0];
      req_len[h]    = rnd[10:3];
      req_qos[h]    = rnd[14:11];
      req_prot[h]   = rnd[16:15];
      req_eom[h]    = rnd[17];
      req_eof[h]    = rnd[18];
      req_ex[h]     = rnd[19];
      req_user[h]   = rnd[21:20];
      req_hostid[h] = rnd[26:22];
      rnd = $random(seed);
      req_uext[h]   = rnd[23:0];
      req_addr[h]   = addr;
      req_wdata[h]  = wdata;
      req_valid[h]  = 1'b1;
      if (op == UMI_REQ_LINK) begin
         req_word = {req_uext[h], 3'd1, op};      // Link is size 1 with extended user
      end else begin
         len_slot = (op == UMI_REQ_ATOMIC) ? at : req_len[h];
         req_word = {req_hostid[h], req_user[h], req_ex[h], req_eof[h], req_eom[h],
                     req_prot[h], req_qos[h], len_slot, req_size[h], op};
      end
      while (!req_ready[h]) @(negedge clk);        // Accepted on the next rising edge
      @(negedge clk);
      req_valid[h] = 1'b0;
      while (!rsp_valid[h]) @(negedge clk);
      rsp_word = rsp_cmd[h];
      rsp_dat  = rsp_data[h];
   endtask

   task automatic read_and_check(input host_sel_t h, input mem_addr_t a, input string what);
      umi_cmd_t  rq;
      umi_cmd_t  rs;
      mem_data_t rd;
      run_request(h, UMI_REQ_READ, UMI_ATOMIC_ADD, a, 32'h0, rq, rs, rd);
      check_cmd({what, " response"}, rs, expect_response(rq, UMI_RESP_READ));
      check_data({what, " data"}, rd, model[a]);
   endtask

   task automatic reset_test();
      check_bit("host 0 req_ready after reset", req_ready[0], 1'b1);
      check_bit("host 1 req_ready after reset", req_ready[1], 1'b1);
      check_bit("host 0 rsp_valid after reset", rsp_valid[0], 1'b0);
      check_bit("host 1 rsp_valid after reset", rsp_valid[1], 1'b0);
   endtask

   task automatic write_read_test();
      mem_addr_t   addrs [16];
      umi_cmd_t    rq;
      umi_cmd_t    rs;
      mem_data_t   rd;
      mem_data_t   wd;
      logic [31:0] rnd;
      for (int i = 0; i < 16; i++) begin
         rnd = $random(seed);
         addrs[i] = rnd[7:0];
         wd = $random(seed);
         run_request(HOST0, UMI_REQ_WRITE, UMI_ATOMIC_ADD, addrs[i], wd, rq, rs, rd);
         model[addrs[i]] = wd;
         check_cmd("write response", rs, expect_response(rq, UMI_RESP_WRITE));
      end
      for (int i = 0; i < 16; i++) read_and_check(HOST0, addrs[i], "read back");
   endtask

   task automatic atomic_test();
      umi_cmd_t  rq;
      umi_cmd_t  rs;
      mem_data_t rd;
      mem_data_t wd;
      mem_addr_t a;
      for (int i = 0; i < 4; i++) begin
         a  = {6'b100000, i[1:0]};
         wd = $random(seed);
         run_request(HOST1, UMI_REQ_WRITE, UMI_ATOMIC_ADD, a, wd, rq, rs, rd);
         model[a] = wd;                           // Known start value
         wd = $random(seed);
         run_request(HOST1, UMI_REQ_ATOMIC, UMI_ATOMIC_ADD, a, wd, rq, rs, rd);
         check_cmd("atomic add response", rs, expect_response(rq, UMI_RESP_READ));
         check_data("atomic add old value", rd, model[a]);
         model[a] = model[a] + wd;
         read_and_check(HOST1, a, "read after atomic add");
         wd = $random(seed);
         run_request(HOST1, UMI_REQ_ATOMIC, UMI_ATOMIC_SWAP, a, wd, rq, rs, rd);
         check_cmd("atomic swap response", rs, expect_response(rq, UMI_RESP_READ));
         check_data("atomic swap old value", rd, model[a]);
         model[a] = wd;
         read_and_check(HOST1, a, "read after atomic swap");
      end
   endtask

   task automatic link_error_test();
      umi_cmd_t  rq;
      umi_cmd_t  rs;
      mem_data_t rd;
      mem_data_t wd;
      wd = $random(seed);                         // Must not reach memory
      run_request(HOST0, UMI_REQ_LINK, UMI_ATOMIC_ADD, 8'h80, wd, rq, rs, rd);
      check_cmd("link response", rs, expect_response(rq, UMI_RESP_LINK));
      run_request(HOST0, UNDEF_OPCODE, UMI_ATOMIC_ADD, 8'h80, wd, rq, rs, rd);
      check_cmd("undefined opcode error response", rs, expect_response(rq, UMI_RESP_ERROR));
      run_request(HOST1, UMI_REQ_ATOMIC, 8'h03, 8'h80, wd, rq, rs, rd);
      check_cmd("atomic atype 3 error response", rs, expect_response(rq, UMI_RESP_ERROR));
      read_and_check(HOST0, 8'h80, "read after link and errors");
   endtask

   task automatic contention_test();
      umi_cmd_t    rq0;
      umi_cmd_t    rs0;
      umi_cmd_t    rq1;
      umi_cmd_t    rs1;
      mem_data_t   rd0;
      mem_data_t   rd1;
      mem_data_t   wd0;
      mem_data_t   wd1;
      mem_addr_t   a0;
      mem_addr_t   a1;
      logic [31:0] rnd;
      for (int i = 0; i < 4; i++) begin           // Host 1 owns C0 to C3
         wd1 = $random(seed);
         run_request(HOST1, UMI_REQ_WRITE, UMI_ATOMIC_ADD, {6'b110000, i[1:0]}, wd1,
                     rq1, rs1, rd1);
         model[{6'b110000, i[1:0]}] = wd1;
      end
      done_order.delete();
      fork
         begin                                    // Host 0 in the lower half
            for (int i = 0; i < 20; i++) begin
               if (i % 2 == 0) begin
                  rnd = $random(seed);
                  a0  = {1'b0, rnd[6:0]};
                  wd0 = $random(seed);
                  run_request(HOST0, UMI_REQ_WRITE, UMI_ATOMIC_ADD, a0, wd0, rq0, rs0, rd0);
                  model[a0] = wd0;
                  check_cmd("contention write response", rs0,
                            expect_response(rq0, UMI_RESP_WRITE));
               end else begin
                  run_request(HOST0, UMI_REQ_READ, UMI_ATOMIC_ADD, a0, 32'h0, rq0, rs0, rd0);
                  check_cmd("contention read response", rs0,
                            expect_response(rq0, UMI_RESP_READ));
                  check_data("contention read data", rd0, model[a0]);
               end
               done_order.push_back(HOST0);
            end
         end
         begin
            for (int j = 0; j < 20; j++) begin
               a1  = {6'b110000, j[1:0]};
               wd1 = $random(seed);
               run_request(HOST1, UMI_REQ_ATOMIC, UMI_ATOMIC_ADD, a1, wd1, rq1, rs1, rd1);
               check_cmd("contention atomic response", rs1,
                         expect_response(rq1, UMI_RESP_READ));
               check_data("contention atomic old value", rd1, model[a1]);
               model[a1] = model[a1] + wd1;
               done_order.push_back(HOST1);
            end
         end
      join
      // Host 1 granted last before the fork loses the first tie
      check_host("first tie winner", done_order[0], HOST0);
      // Round-robin means no host completes twice in a row
      for (int i = 1; i < done_order.size(); i++) begin
         check_host("completion order", done_order[i], ~done_order[i-1]);
      end
      // Host 0 granted last here, so the next tie goes to host 1
      read_and_check(HOST0, a0, "read before tie");
      done_order.delete();
      fork
         begin
            read_and_check(HOST0, a0, "tie read host 0");
            done_order.push_back(HOST0);
         end
         begin
            read_and_check(HOST1, 8'hc0, "tie read host 1");
            done_order.push_back(HOST1);
         end
      join
      check_host("tie winner after host 0", done_order[0], HOST1);
   endtask

   initial begin
      init_inputs();
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      reset_test();
      write_read_test();
      atomic_test();
      link_error_test();
      contention_test();
      @(negedge clk);
      $display("Checks: %0d  errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

/* vlog.f */
umi_pkg.sv
umi_mem_pkg.sv
umi_decode.sv
umi_pack.sv
umi_host_port.sv
umi_arbiter.sv
umi_mem_target.sv
umi_mem_top.sv
tb_umi_mem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_umi_mem
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0
PASS_MSG  := ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF -- "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
